//--- vlog.f
common/perf_pkg.sv
common/cache_port_pkg.sv
source/report_trigger.sv
perf_monitor/dcache_fire_tally.sv
perf_monitor/pending_read_tracker.sv
perf_monitor/perf_monitor.sv
+incdir+verification
verification/perf_monitor_tb.sv

//--- run.sh
#!/bin/sh
# build and run the perf_monitor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
    -f vlog.f \
    --top-module perf_monitor_tb \
    --Mdir obj_dir \
    -o perf_monitor_sim

output="$(./obj_dir/perf_monitor_sim)"
echo "$output"

if echo "$output" | grep -qx "Result: PASSED"; then
    exit 0
else
    exit 1
fi

//--- verification/perf_monitor_tests.svh
////////////////////////////////////////////////////////////
// perf monitor stimulus table
// one row per test and the LFSR used for random picks
////////////////////////////////////////////////////////////

`ifndef PERF_MONITOR_TESTS_SVH
`define PERF_MONITOR_TESTS_SVH

// probabilities are in sixteenths, 16 means every cycle
typedef struct packed {
    logic [15:0]                cycles;
    logic [4:0]                 ireq_prob;
    logic [4:0]                 irsp_prob;
    cache_port_pkg::lane_mask_t lane_valid;
    cache_port_pkg::lane_mask_t lane_rw;
    cache_port_pkg::lane_mask_t lane_rsp;
    logic [7:0]                 busy_pattern;
    logic                       reset_first;
} test_row_t;

localparam int num_tests = 6;

// cycles, ireq, irsp, valid, rw, rsp, busy, reset first
function automatic test_row_t get_row(input int idx);
    test_row_t row;
    case (idx)
        // fetch traffic only, busy never falls
        0: row = '{16'd40, 5'd10, 5'd6, 4'h0, 4'h0, 4'h0, 8'hff, 1'b0};
        // loads on every lane
        1: row = '{16'd48, 5'd0, 5'd0, 4'hf, 4'h0, 4'hf, 8'h0f, 1'b0};
        // loads and stores mixed within a cycle
        2: row = '{16'd40, 5'd8, 5'd8, 4'hf, 4'hf, 4'h5, 8'haa, 1'b0};
        // everything active after a mid-run reset
        3: row = '{16'd60, 5'd12, 5'd9, 4'hf, 4'ha, 4'hf, 8'hf0, 1'b1};
        // two lanes, lane 1 may store
        4: row = '{16'd30, 5'd16, 5'd16, 4'h3, 4'h2, 4'h3, 8'h00, 1'b0};
        // sparse traffic on the top lane
        5: row = '{16'd30, 5'd4, 5'd4, 4'h8, 4'h8, 4'h8, 8'hcc, 1'b1};
        default: row = '0;
    endcase
    return row;
endfunction

// fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

`endif

//--- verification/perf_monitor_tb.sv
////////////////////////////////////////////////////////////
// perf monitor testbench
// drives random cache traffic from a table of tests, runs a
// cycle model of the counters and compares the outputs
////////////////////////////////////////////////////////////

module perf_monitor_tb;

    timeunit 1ns;
    timeprecision 1ps;

    `include "perf_monitor_tests.svh"

    localparam int report_interval_tb = 20;

    logic                       clk;
    logic                       reset;
    logic                       busy;
    logic                       icache_req_valid;
    logic                       icache_req_ready;
    logic                       icache_rsp_valid;
    logic                       icache_rsp_ready;
    cache_port_pkg::lane_mask_t dcache_req_valid;
    cache_port_pkg::lane_mask_t dcache_req_ready;
    cache_port_pkg::lane_mask_t dcache_req_rw;
    cache_port_pkg::lane_mask_t dcache_rsp_valid;
    cache_port_pkg::lane_mask_t dcache_rsp_ready;
    perf_pkg::perf_ctr_t        ifetches;
    perf_pkg::perf_ctr_t        ifetch_latency;
    perf_pkg::perf_ctr_t        loads;
    perf_pkg::perf_ctr_t        stores;
    perf_pkg::perf_ctr_t        load_latency;
    logic                       report;

    // reference model state
    perf_pkg::perf_ctr_t        m_ifetches;
    perf_pkg::perf_ctr_t        m_ifetch_latency;
    perf_pkg::perf_ctr_t        m_loads;
    perf_pkg::perf_ctr_t        m_stores;
    perf_pkg::perf_ctr_t        m_load_latency;
    perf_pkg::pending_t         m_ipending;
    perf_pkg::pending_t         m_dpending;
    cache_port_pkg::lane_mask_t m_rd_held;
    cache_port_pkg::lane_mask_t m_wr_held;
    logic                       m_busy_prev;
    int                         m_interval;
    logic                       m_report;

    logic [31:0] lfsr_state = 32'd94605;
    int          error_count = 0;
    int          cycle_count = 0;
    int          timeout_limit = 0;
    logic        checking = 1'b0;

    perf_monitor #(
        .report_interval (report_interval_tb)
    ) perf_monitor_inst (
        .clk              (clk),
        .reset            (reset),
        .busy             (busy),
        .icache_req_valid (icache_req_valid),
        .icache_req_ready (icache_req_ready),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp_ready (icache_rsp_ready),
        .dcache_req_valid (dcache_req_valid),
        .dcache_req_ready (dcache_req_ready),
        .dcache_req_rw    (dcache_req_rw),
        .dcache_rsp_valid (dcache_rsp_valid),
        .dcache_rsp_ready (dcache_rsp_ready),
        .ifetches         (ifetches),
        .ifetch_latency   (ifetch_latency),
        .loads            (loads),
        .stores           (stores),
        .load_latency     (load_latency),
        .report           (report)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic next_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    // true with probability prob/16
    function automatic logic chance(input logic [4:0] prob);
        logic [4:0] draw;
        draw = '0;
        for (int i = 0; i < 4; i++) begin
            draw[i] = next_bit();
        end
        return draw < prob;
    endfunction

    function automatic cache_port_pkg::lane_mask_t random_mask();
        cache_port_pkg::lane_mask_t mask;
        for (int i = 0; i < cache_port_pkg::dcache_lanes; i++) begin
            mask[i] = next_bit();
        end
        return mask;
    endfunction

    function automatic int count_ones(input cache_port_pkg::lane_mask_t mask);
        int total;
        total = 0;
        for (int i = 0; i < cache_port_pkg::dcache_lanes; i++) begin
            if (mask[i]) begin
                total++;
            end
        end
        return total;
    endfunction

    // model sees the inputs as sampled at the edge
    always @(posedge clk) begin : model_update
        logic i_req;
        logic i_rsp;
        int   d_load;
        int   d_store;
        int   d_rsp;
        i_req   = icache_req_valid & icache_req_ready;
        i_rsp   = icache_rsp_valid & icache_rsp_ready;
        d_load  = count_ones(m_rd_held);
        d_store = count_ones(m_wr_held);
        d_rsp   = count_ones(dcache_rsp_valid & dcache_rsp_ready);
        if (reset) begin
            m_ifetches       <= '0;
            m_ifetch_latency <= '0;
            m_loads          <= '0;
            m_stores         <= '0;
            m_load_latency   <= '0;
            m_ipending       <= '0;
            m_dpending       <= '0;
            m_rd_held        <= '0;
            m_wr_held        <= '0;
            m_busy_prev      <= 1'b0;
            m_interval       <= 0;
            m_report         <= 1'b0;
        end else begin
            // latency takes the pending count from before this edge
            m_ifetch_latency <= m_ifetch_latency + perf_pkg::perf_ctr_t'(m_ipending);
            m_load_latency   <= m_load_latency + perf_pkg::perf_ctr_t'(m_dpending);
            m_ipending <= m_ipending + perf_pkg::pending_t'(i_req) - perf_pkg::pending_t'(i_rsp);
            m_dpending <= m_dpending + perf_pkg::pending_t'(d_load) - perf_pkg::pending_t'(d_rsp);
            m_ifetches <= m_ifetches + perf_pkg::perf_ctr_t'(i_req);
            m_loads    <= m_loads + perf_pkg::perf_ctr_t'(d_load);
            m_stores   <= m_stores + perf_pkg::perf_ctr_t'(d_store);
            m_rd_held  <= dcache_req_valid & dcache_req_ready & ~dcache_req_rw;
            m_wr_held  <= dcache_req_valid & dcache_req_ready & dcache_req_rw;
            m_report   <= (m_busy_prev & ~busy) | (m_interval == report_interval_tb);
            m_interval <= (m_interval == report_interval_tb) ? 0 : m_interval + 1;
            m_busy_prev <= busy;
        end
    end

    task automatic show_mismatch(
        input string               name,
        input perf_pkg::perf_ctr_t got,
        input perf_pkg::perf_ctr_t expected
    );
        $display("MISMATCH at %0d ns: %s is %0d, expected %0d", $time, name, got, expected);
        error_count++;
    endtask

    // report strobe compared every cycle
    always @(negedge clk) begin
        if (checking) begin
            assert (report == m_report)
                else show_mismatch("report", perf_pkg::perf_ctr_t'(report),
                                   perf_pkg::perf_ctr_t'(m_report));
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic drive_idle();
        @(posedge clk);
        busy             <= 1'b0;
        icache_req_valid <= 1'b0;
        icache_req_ready <= 1'b0;
        icache_rsp_valid <= 1'b0;
        icache_rsp_ready <= 1'b0;
        dcache_req_valid <= '0;
        dcache_req_ready <= '0;
        dcache_req_rw    <= '0;
        dcache_rsp_valid <= '0;
        dcache_rsp_ready <= '0;
    endtask

    task automatic drive_cycle(input test_row_t row, input int idx);
        @(posedge clk);
        busy             <= row.busy_pattern[idx[2:0]];
        icache_req_valid <= chance(row.ireq_prob);
        icache_req_ready <= next_bit();
        icache_rsp_valid <= chance(row.irsp_prob);
        icache_rsp_ready <= next_bit();
        dcache_req_valid <= row.lane_valid & random_mask();
        dcache_req_ready <= random_mask();
        dcache_req_rw    <= row.lane_rw & random_mask();
        dcache_rsp_valid <= row.lane_rsp & random_mask();
        dcache_rsp_ready <= random_mask();
    endtask

    // reset held over three rising edges before every output is checked for 0
    task automatic apply_reset();
        drive_idle();
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (ifetches == 0 && ifetch_latency == 0 && loads == 0 && stores == 0
                && load_latency == 0 && report == 1'b0)
            else begin
                $display("reset did not clear the counters and report at %0d ns", $time);
                error_count++;
            end
    endtask

    task automatic check_counters();
        @(negedge clk);
        assert (ifetches == m_ifetches)
            else show_mismatch("ifetches", ifetches, m_ifetches);
        assert (ifetch_latency == m_ifetch_latency)
            else show_mismatch("ifetch_latency", ifetch_latency, m_ifetch_latency);
        assert (loads == m_loads)
            else show_mismatch("loads", loads, m_loads);
        assert (stores == m_stores)
            else show_mismatch("stores", stores, m_stores);
        assert (load_latency == m_load_latency)
            else show_mismatch("load_latency", load_latency, m_load_latency);
    endtask

    initial begin : run_tests
        test_row_t row;
        int        errors_before;
        int        failed_tests;
        int        total_cycles;
        failed_tests = 0;
        total_cycles = 0;
        for (int t = 0; t < num_tests; t++) begin
            row = get_row(t);
            total_cycles += int'(row.cycles);
        end
        timeout_limit = total_cycles + 50;

        reset            <= 1'b1;
        busy             <= 1'b0;
        icache_req_valid <= 1'b0;
        icache_req_ready <= 1'b0;
        icache_rsp_valid <= 1'b0;
        icache_rsp_ready <= 1'b0;
        dcache_req_valid <= '0;
        dcache_req_ready <= '0;
        dcache_req_rw    <= '0;
        dcache_rsp_valid <= '0;
        dcache_rsp_ready <= '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checking = 1'b1;

        for (int t = 0; t < num_tests; t++) begin
            row = get_row(t);
            errors_before = error_count;
            if (row.reset_first) begin
                apply_reset();
            end
            for (int c = 0; c < int'(row.cycles); c++) begin
                drive_cycle(row, c);
            end
            // let buffered fires and responses settle
            repeat (2) drive_idle();
            check_counters();
            if (error_count != errors_before) begin
                failed_tests++;
            end
            $display("test %0d: %0d cycles, ifetches %0d, loads %0d, stores %0d, %0d errors",
                     t, row.cycles, ifetches, loads, stores, error_count - errors_before);
        end

        $display("%0d tests run, %0d with errors, %0d errors in total",
                 num_tests, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- perf_monitor/perf_monitor.sv
////////////////////////////////////////////////////////////
// memory-side performance monitor
// observes the icache and dcache ports of one core, keeps
// fetch, load, store and latency counters and a report strobe
////////////////////////////////////////////////////////////

module perf_monitor #(
    parameter int report_interval = perf_pkg::report_interval_default,
    parameter int num_lanes       = cache_port_pkg::dcache_lanes
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       busy,

    // instruction cache port
    input  logic                       icache_req_valid,
    input  logic                       icache_req_ready,
    input  logic                       icache_rsp_valid,
    input  logic                       icache_rsp_ready,

    // data cache port, one bit per lane
    input  cache_port_pkg::lane_mask_t dcache_req_valid,
    input  cache_port_pkg::lane_mask_t dcache_req_ready,
    input  cache_port_pkg::lane_mask_t dcache_req_rw,
    input  cache_port_pkg::lane_mask_t dcache_rsp_valid,
    input  cache_port_pkg::lane_mask_t dcache_rsp_ready,

    output perf_pkg::perf_ctr_t        ifetches,
    output perf_pkg::perf_ctr_t        ifetch_latency,
    output perf_pkg::perf_ctr_t        loads,
    output perf_pkg::perf_ctr_t        stores,
    output perf_pkg::perf_ctr_t        load_latency,
    output logic                       report
);

    cache_port_pkg::fetch_count_t icache_req_fire;
    cache_port_pkg::fetch_count_t icache_rsp_fire;

    cache_port_pkg::lane_count_t  dcache_load_count;
    cache_port_pkg::lane_count_t  dcache_rsp_count;

    // single-request port, fires feed the tracker directly
    assign icache_req_fire = icache_req_valid & icache_req_ready;
    assign icache_rsp_fire = icache_rsp_valid & icache_rsp_ready;

    dcache_fire_tally #(
        .num_lanes        (num_lanes)
    ) dcache_fire_tally_inst (
        .clk              (clk),
        .reset            (reset),
        .dcache_req_valid (dcache_req_valid),
        .dcache_req_ready (dcache_req_ready),
        .dcache_req_rw    (dcache_req_rw),
        .dcache_rsp_valid (dcache_rsp_valid),
        .dcache_rsp_ready (dcache_rsp_ready),
        .load_count       (dcache_load_count),
        .rsp_count        (dcache_rsp_count),
        .stores           (stores)
    );

    pending_read_tracker #(
        .count_t   (cache_port_pkg::fetch_count_t)
    ) icache_tracker (
        .clk       (clk),
        .reset     (reset),
        .req_count (icache_req_fire),
        .rsp_count (icache_rsp_fire),
        .requests  (ifetches),
        .latency   (ifetch_latency)
    );

    // load count arrives one cycle late from the tally buffer
    pending_read_tracker #(
        .count_t   (cache_port_pkg::lane_count_t)
    ) dcache_tracker (
        .clk       (clk),
        .reset     (reset),
        .req_count (dcache_load_count),
        .rsp_count (dcache_rsp_count),
        .requests  (loads),
        .latency   (load_latency)
    );

    report_trigger #(
        .report_interval (report_interval)
    ) report_trigger_inst (
        .clk    (clk),
        .reset  (reset),
        .busy   (busy),
        .report (report)
    );

endmodule

//--- perf_monitor/pending_read_tracker.sv
////////////////////////////////////////////////////////////
// pending read tracker
// totals accepted reads for one cache port, keeps the number
// still outstanding and accumulates it as read latency
////////////////////////////////////////////////////////////

module pending_read_tracker #(
    parameter type count_t = cache_port_pkg::lane_count_t
) (
    input  logic                clk,
    input  logic                reset,

    // reads accepted and returned this cycle
    input  count_t              req_count,
    input  count_t              rsp_count,

    output perf_pkg::perf_ctr_t requests,
    output perf_pkg::perf_ctr_t latency
);

    perf_pkg::pending_t pending;
    perf_pkg::pending_t req_ext;
    perf_pkg::pending_t rsp_ext;
    perf_pkg::pending_t pending_delta;

    // counts are unsigned, widen before taking the difference
    assign req_ext       = perf_pkg::pending_t'(req_count);
    assign rsp_ext       = perf_pkg::pending_t'(rsp_count);
    assign pending_delta = req_ext - rsp_ext;

    always_ff @(posedge clk) begin
        if (reset) begin
            requests <= '0;
        end else begin
            requests <= requests + perf_pkg::perf_ctr_t'(req_count);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= pending + pending_delta;
        end
    end

    // each cycle every outstanding read adds one cycle of latency
    // uses the count held before the edge, so a read accepted at
    // this edge only starts adding from the next one
    always_ff @(posedge clk) begin
        if (reset) begin
            latency <= '0;
        end else begin
            latency <= latency + perf_pkg::perf_ctr_t'(pending);
        end
    end

endmodule

//--- perf_monitor/dcache_fire_tally.sv
////////////////////////////////////////////////////////////
// dcache fire tally
// per-lane load, store and response fire detection with a
// one-cycle request buffer, population counts, store total
////////////////////////////////////////////////////////////

module dcache_fire_tally #(
    parameter int num_lanes = cache_port_pkg::dcache_lanes
) (
    input  logic                        clk,
    input  logic                        reset,

    input  cache_port_pkg::lane_mask_t  dcache_req_valid,
    input  cache_port_pkg::lane_mask_t  dcache_req_ready,
    input  cache_port_pkg::lane_mask_t  dcache_req_rw,
    input  cache_port_pkg::lane_mask_t  dcache_rsp_valid,
    input  cache_port_pkg::lane_mask_t  dcache_rsp_ready,

    output cache_port_pkg::lane_count_t load_count,
    output cache_port_pkg::lane_count_t rsp_count,
    output perf_pkg::perf_ctr_t         stores
);

    cache_port_pkg::lane_mask_t  rd_fire;
    cache_port_pkg::lane_mask_t  wr_fire;
    cache_port_pkg::lane_mask_t  rsp_fire;
    cache_port_pkg::lane_mask_t  rd_fire_r;
    cache_port_pkg::lane_mask_t  wr_fire_r;
    cache_port_pkg::lane_count_t wr_count;

    // number of set bits among the active lanes
    function automatic cache_port_pkg::lane_count_t pop_count(
        input cache_port_pkg::lane_mask_t mask
    );
        cache_port_pkg::lane_count_t total;
        total = '0;
        for (int i = 0; i < num_lanes; i++) begin
            total = total + cache_port_pkg::lane_count_t'(mask[i]);
        end
        return total;
    endfunction

    // a lane fires when valid and ready meet, rw picks store
    always_comb begin
        rd_fire  = '0;
        wr_fire  = '0;
        rsp_fire = '0;
        for (int i = 0; i < num_lanes; i++) begin
            rd_fire[i]  = dcache_req_valid[i] & dcache_req_ready[i] & ~dcache_req_rw[i];
            wr_fire[i]  = dcache_req_valid[i] & dcache_req_ready[i] & dcache_req_rw[i];
            rsp_fire[i] = dcache_rsp_valid[i] & dcache_rsp_ready[i];
        end
    end

    // request fires held for one cycle before counting
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_fire_r <= '0;
            wr_fire_r <= '0;
        end else begin
            rd_fire_r <= rd_fire;
            wr_fire_r <= wr_fire;
        end
    end

    assign load_count = pop_count(rd_fire_r);
    assign wr_count   = pop_count(wr_fire_r);

    // responses are counted in the cycle they fire
    assign rsp_count  = pop_count(rsp_fire);

    always_ff @(posedge clk) begin
        if (reset) begin
            stores <= '0;
        end else begin
            stores <= stores + perf_pkg::perf_ctr_t'(wr_count);
        end
    end

endmodule

//--- source/report_trigger.sv
////////////////////////////////////////////////////////////
// report trigger
// one-cycle report strobe on a busy falling edge and at a
// fixed cycle interval
////////////////////////////////////////////////////////////

module report_trigger #(
    parameter int report_interval = 10000
) (
    input  logic clk,
    input  logic reset,
    input  logic busy,
    output logic report
);

    // wide enough to hold report_interval, at least one bit
    localparam int interval_bits = $clog2(report_interval + 2);

    logic                     busy_prev;
    logic [interval_bits-1:0] interval_count;
    logic                     busy_fall;
    logic                     interval_wrap;

    assign busy_fall     = busy_prev & ~busy;
    assign interval_wrap = (interval_count == interval_bits'(report_interval));

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_prev <= 1'b0;
        end else begin
            busy_prev <= busy;
        end
    end

    // counts 0 .. report_interval, then starts over
    always_ff @(posedge clk) begin
        if (reset) begin
            interval_count <= '0;
        end else if (interval_wrap) begin
            interval_count <= '0;
        end else begin
            interval_count <= interval_count + 1'b1;
        end
    end

    // either source raises the strobe for the next cycle only
    always_ff @(posedge clk) begin
        if (reset) begin
            report <= 1'b0;
        end else begin
            report <= busy_fall | interval_wrap;
        end
    end

endmodule

//--- common/cache_port_pkg.sv
////////////////////////////////////////////////////////////
// cache port definitions
// lane count and per-lane mask and count types
////////////////////////////////////////////////////////////

package cache_port_pkg;

    // request lanes on the data-cache port
    localparam int dcache_lanes = 4;

    // one bit per data-cache lane
    typedef logic [dcache_lanes-1:0] lane_mask_t;

    // lanes firing in one cycle, 0 to dcache_lanes
    typedef logic [$clog2(dcache_lanes+1)-1:0] lane_count_t;

    // instruction port fires at most once per cycle
    typedef logic fetch_count_t;

endpackage

//--- common/perf_pkg.sv
////////////////////////////////////////////////////////////
// perf counter definitions
// counter width, counter types and report interval default
// for the memory-side performance monitor
////////////////////////////////////////////////////////////

package perf_pkg;

    // width shared by every performance counter
    localparam int perf_ctr_bits = 44;

    // free-running event and latency totals
    typedef logic [perf_ctr_bits-1:0] perf_ctr_t;

    // outstanding-read count
    // kept signed so a transient negative value (response seen
    // before its buffered request) stays well defined
    typedef logic signed [perf_ctr_bits-1:0] pending_t;

    // cycles between periodic reports
    localparam int report_interval_default = 10000;

endpackage
